/* vlog.f */
src/flash_cmd_pkg.sv
src/flash_buf_pkg.sv
src/cmd_level_if.sv
src/byte_ram.sv
src/edge_latch.sv
src/cmd_decode.sv
src/flash_strobe.sv
src/read_capture.sv
src/write_sequencer.sv
src/status_reg.sv
src/flash_prog_top.sv
verif/tb_flash_prog.sv

/* verif/tb_flash_prog.sv */
// testbench for the flash programming bridge with a flash model and directed tests
module tb_flash_prog;
	import flash_cmd_pkg::*;

	localparam int WAIT_LIMIT = 1000;	// cycles per wait loop

	logic        clock_rd2, rst_n, host_wr_strobe, flash_busy, flash_data_valid;
	logic        flash_illegal_write, flash_illegal_erase;
	logic [7:0]  cmd, host_rd_addr, flash_dout, rd_data, flash_din;
	logic [15:0] host_data;
	logic [31:0] flash_addr_in, status, flash_addr;
	logic        flash_read, flash_rden, flash_write, flash_sector_erase;
	logic        flash_en4b, flash_wren, flash_shift_bytes;

	int         errors, err_mark, tests, tests_bad;
	int         n_read, n_erase, n_en4b, n_write, n_wren, n_shift, n_shift_wren, n_cmd_wren;
	logic [7:0] din_q[$];	// bytes seen on flash_din
	logic [7:0] rbytes[$];	// bytes the model returned
	logic [7:0] wexp[256];	// expected write buffer
	logic       rden_s, phase;

	flash_prog_top dut (.*);

	always #10 clock_rd2 = ~clock_rd2;

	// ========================================
	// flash model samples at +1 and drives at +2
	// ========================================
	always @(posedge clock_rd2) begin
		#1;
		if (flash_read) n_read++;
		if (flash_sector_erase) n_erase++;
		if (flash_en4b) n_en4b++;
		if (flash_write) n_write++;
		if (flash_wren) n_wren++;
		if ((flash_sector_erase || flash_en4b) && flash_wren) n_cmd_wren++;
		if (flash_shift_bytes) begin
			n_shift++;
			if (flash_wren) n_shift_wren++;
			din_q.push_back(flash_din);	// one byte per shift
		end
		rden_s = flash_rden;
		#1;
		if (!phase && rden_s) begin	// one byte every other cycle
			flash_data_valid = 1'b1;
			flash_dout       = 8'($urandom);
			rbytes.push_back(flash_dout);
			phase            = 1'b1;
		end else begin
			flash_data_valid = 1'b0;
			phase            = 1'b0;
		end
	end

	function automatic logic [7:0] flip_byte(input logic [7:0] b);
		logic [7:0] r;
		for (int i = 0; i < 8; i++)
			r[i] = b[7-i];
		return r;
	endfunction

	task automatic step();	// to 2 units past the next rising edge
		@(posedge clock_rd2);
		#2;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("** Error %s: got %0h, expected %0h", name, got, exp);
	endtask

	task automatic note_timeout(input string what);
		errors++;
		$display("timeout while waiting for %s", what);
	endtask

	task automatic clear_counts();
		n_read       = 0;
		n_erase      = 0;
		n_en4b       = 0;
		n_write      = 0;
		n_wren       = 0;
		n_shift      = 0;
		n_shift_wren = 0;
		n_cmd_wren   = 0;
		din_q.delete();
		rbytes.delete();
	endtask

	task automatic wait_status(input int bit_pos, input logic val, input string what);
		int n;
		n = 0;
		while (status[bit_pos] !== val && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (status[bit_pos] !== val) note_timeout(what);
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != err_mark) tests_bad++;
		$display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "mismatch");
		err_mark = errors;
	endtask

	task automatic write_byte(input logic [7:0] addr, input logic [7:0] data);
		host_data      = {addr, data};
		host_wr_strobe = 1'b1;
		step();
		host_wr_strobe = 1'b0;
		step();
		wexp[addr] = data;
	endtask

	// ========================================
	// directed tests
	// ========================================
	task automatic reset_state();
		logic [3:0] strobes;
		logic [2:0] enables;
		strobes = {flash_read, flash_write, flash_sector_erase, flash_en4b};
		enables = {flash_wren, flash_shift_bytes, flash_rden};
		if (strobes !== 4'h0) report_mismatch("flash strobes", strobes, 0);
		if (enables !== 3'h0) report_mismatch("wren/shift/rden", enables, 0);
		if (status !== 32'h0) report_mismatch("status", status, 0);
		end_test("reset");
	endtask

	task automatic buffer_fill();
		logic [7:0] addr[8];
		cmd = OP_BUF_WRITE;
		wait_status(7, 1'b1, "buffer write mode");
		for (int i = 0; i < 8; i++) begin
			addr[i] = 8'($urandom);
			write_byte(addr[i], 8'($urandom));
		end
		for (int i = 0; i < 8; i++) begin
			host_data = {addr[i], 8'h00};	// readback through port a
			repeat (3) step();
			if (status[31:24] !== wexp[addr[i]])
				report_mismatch("status[31:24]", status[31:24], wexp[addr[i]]);
			if (status[7] !== 1'b1) report_mismatch("status[7]", status[7], 1);
		end
		end_test("buffer write");
	endtask

	task automatic page_program();
		int n;
		cmd = OP_BUF_WRITE;
		wait_status(7, 1'b1, "buffer write mode");
		for (int i = 0; i < 128; i++) write_byte(8'(i), 8'($urandom));
		clear_counts();
		cmd = OP_WRITE;
		n = 0;
		while (n_write == 0 && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (n_write == 0) note_timeout("flash_write pulse");
		repeat (6) step();	// no second write pulse may follow
		if (n_shift != 128) report_mismatch("flash_shift_bytes count", n_shift, 128);
		if (n_shift_wren != 128)
			report_mismatch("flash_wren on shift count", n_shift_wren, 128);
		if (n_write != 1) report_mismatch("flash_write count", n_write, 1);
		if (n_wren != 129) report_mismatch("flash_wren count", n_wren, 129);
		for (int i = 0; i < din_q.size() && i < 128; i++)
			if (din_q[i] !== flip_byte(wexp[i]))
				report_mismatch("flash_din", din_q[i], flip_byte(wexp[i]));
		cmd = OP_IDLE;
		repeat (4) step();
		end_test("page program");
	endtask

	task automatic flash_read_back();
		int   n, len, n_valid;
		logic rden_prev;
		len       = 4 + ($urandom % 12);
		host_data = {8'h00, 8'(len)};	// length held steady through the read
		clear_counts();
		cmd = OP_READ;
		n = 0;
		while (flash_rden !== 1'b1 && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (flash_rden !== 1'b1) note_timeout("flash_rden to rise");
		n         = 0;
		n_valid   = 0;
		rden_prev = 1'b1;	// status lags flash_rden by one edge
		while (flash_rden !== 1'b0 && n < WAIT_LIMIT) begin
			step();
			n++;
			if (status[6] !== rden_prev) report_mismatch("status[6]", status[6], rden_prev);
			if (status[1] === 1'b1) n_valid++;	// one per data_valid pulse
			rden_prev = flash_rden;
		end
		if (flash_rden !== 1'b0) note_timeout("flash_rden to fall");
		if (n_read != 1) report_mismatch("flash_read count", n_read, 1);
		if (rbytes.size() != len + 1)
			report_mismatch("read byte count", rbytes.size(), len + 1);
		if (n_valid != len + 1) report_mismatch("status[1] pulse count", n_valid, len + 1);
		cmd = OP_IDLE;
		repeat (3) step();
		for (int i = 0; i <= len && i < rbytes.size(); i++) begin
			host_rd_addr = 8'(i);
			step();	// one cycle read latency
			if (rd_data !== flip_byte(rbytes[i]))
				report_mismatch("rd_data", rd_data, flip_byte(rbytes[i]));
		end
		end_test("read");
	endtask

	task automatic erase_and_en4b();
		int n;
		for (int k = 0; k < 2; k++) begin
			flash_addr_in = $urandom;
			clear_counts();
			cmd = (k == 0) ? OP_ERASE : OP_EXT_ADDR;
			n = 0;
			while (n_erase + n_en4b == 0 && n < WAIT_LIMIT) begin
				step();
				n++;
			end
			if (n_erase + n_en4b == 0) note_timeout("erase or en4b pulse");
			repeat (4) step();
			if (n_erase != (k == 0))
				report_mismatch("flash_sector_erase count", n_erase, k == 0);
			if (n_en4b != (k == 1)) report_mismatch("flash_en4b count", n_en4b, k == 1);
			if (n_cmd_wren != 1) report_mismatch("flash_wren with strobe", n_cmd_wren, 1);
			if (n_wren != 1) report_mismatch("flash_wren count", n_wren, 1);
			if (n_read + n_write + n_shift != 0)
				report_mismatch("other strobes", n_read + n_write + n_shift, 0);
			if (flash_addr !== flash_addr_in)
				report_mismatch("flash_addr", flash_addr, flash_addr_in);
			cmd = OP_IDLE;
			repeat (3) step();
		end
		end_test("erase and ext addr");
	endtask

	task automatic busy_edge_flags();
		flash_busy = 1'b1;
		wait_status(4, 1'b1, "busy rise flag");
		if (status[0] !== 1'b1) report_mismatch("status[0]", status[0], 1);
		flash_busy = 1'b0;
		wait_status(5, 1'b1, "busy fall flag");
		flash_illegal_write = 1'b1;
		flash_illegal_erase = 1'b1;
		repeat (4) step();	// flags must hold
		if (status[5:2] !== 4'hf) report_mismatch("status[5:2]", status[5:2], 4'hf);
		flash_illegal_write = 1'b0;
		flash_illegal_erase = 1'b0;
		cmd = OP_BUSY_CLEAR;
		wait_status(4, 1'b0, "busy rise flag to clear");
		wait_status(5, 1'b0, "busy fall flag to clear");
		cmd = OP_IDLE;
		repeat (4) step();
		if (status[5:2] !== 4'h0) report_mismatch("status[5:2]", status[5:2], 0);
		end_test("busy edges");
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		void'($urandom(32'hefab));
		clock_rd2           = 1'b0;
		rst_n               = 1'b0;
		cmd                 = OP_IDLE;
		host_data           = '0;
		host_wr_strobe      = 1'b0;
		host_rd_addr        = '0;
		flash_addr_in       = '0;
		flash_busy          = 1'b0;
		flash_data_valid    = 1'b0;
		flash_dout          = '0;
		phase               = 1'b0;
		rden_s              = 1'b0;
		flash_illegal_write = 1'b0;
		flash_illegal_erase = 1'b0;
		errors              = 0;
		err_mark            = 0;
		tests               = 0;
		tests_bad           = 0;
		clear_counts();
		repeat (16) @(posedge clock_rd2);
		#2 rst_n = 1'b1;
		step();
		reset_state();
		buffer_fill();
		page_program();
		flash_read_back();
		erase_and_en4b();
		busy_edge_flags();
		$display("tests run %0d, tests failed %0d, errors %0d", tests, tests_bad, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* src/flash_prog_top.sv */
// flash programming bridge top, host opcodes to serial flash controller strobes
module flash_prog_top (
	input  logic                                clock_rd2,
	input  logic                                rst_n,
	input  logic [flash_cmd_pkg::CMD_W-1:0]     cmd,
	input  logic [15:0]                         host_data,	// 15:8 wr addr, 7:0 byte or length
	input  logic                                host_wr_strobe,
	input  logic [flash_buf_pkg::BUF_AW-1:0]    host_rd_addr,
	input  logic [flash_buf_pkg::FLASH_AW-1:0]  flash_addr_in,
	input  logic                                flash_busy,
	input  logic                                flash_data_valid,
	input  logic [flash_buf_pkg::BYTE_W-1:0]    flash_dout,
	input  logic                                flash_illegal_write,
	input  logic                                flash_illegal_erase,
	output logic [flash_buf_pkg::BYTE_W-1:0]    rd_data,
	output logic [31:0]                         status,
	output logic                                flash_read,
	output logic                                flash_rden,
	output logic                                flash_write,
	output logic                                flash_sector_erase,
	output logic                                flash_en4b,
	output logic                                flash_wren,
	output logic                                flash_shift_bytes,
	output logic [flash_buf_pkg::BYTE_W-1:0]    flash_din,
	output logic [flash_buf_pkg::FLASH_AW-1:0]  flash_addr
);
	import flash_buf_pkg::*;

	cmd_level_if lv ();

	logic                  busy_q;
	logic                  write_done;
	logic [BUSY_EDGES-1:0] busy_flags;	// 0 rise, 1 fall
	logic [BYTE_W-1:0]     wbuf_byte;

	cmd_decode u_dec (.clock_rd2(clock_rd2), .rst_n(rst_n), .cmd(cmd), .lv(lv.src));

	flash_strobe u_strb (
		.clock_rd2(clock_rd2), .rst_n(rst_n), .lv(lv.strobe),
		.write_done(write_done), .shift_bytes(flash_shift_bytes),
		.flash_busy(flash_busy), .flash_addr_in(flash_addr_in),
		.flash_read(flash_read), .flash_sector_erase(flash_sector_erase),
		.flash_en4b(flash_en4b), .flash_write(flash_write), .flash_wren(flash_wren),
		.flash_addr(flash_addr), .busy_q(busy_q)
	);

	// ========================================
	// busy edge flags, fall watches inverted busy
	// ========================================
	for (genvar i = 0; i < BUSY_EDGES; i++) begin : g_busy_edge
		edge_latch #(.PREV_INIT(i != 0)) u_edge (
			.clock_rd2(clock_rd2), .rst_n(rst_n),
			.level((i == 0) ? busy_q : !busy_q),
			.clear(lv.busy_clear), .flag(busy_flags[i])
		);
	end

	read_capture u_rcap (
		.clock_rd2(clock_rd2), .rst_n(rst_n), .lv(lv.reader),
		.read_len(host_data[7:0]), .flash_data_valid(flash_data_valid),
		.flash_dout(flash_dout), .host_rd_addr(host_rd_addr),
		.flash_rden(flash_rden), .rd_data(rd_data)
	);

	write_sequencer u_wseq (
		.clock_rd2(clock_rd2), .rst_n(rst_n), .lv(lv.writer),
		.host_wr_strobe(host_wr_strobe), .host_wr_addr(host_data[15:8]),
		.host_wr_byte(host_data[7:0]), .wbuf_byte(wbuf_byte), .flash_din(flash_din),
		.shift_bytes(flash_shift_bytes), .write_done(write_done)
	);

	status_reg u_stat (
		.clock_rd2(clock_rd2), .rst_n(rst_n), .lv(lv.stat), .busy_q(busy_q),
		.flash_data_valid(flash_data_valid), .flash_illegal_write(flash_illegal_write),
		.flash_illegal_erase(flash_illegal_erase), .flash_rden(flash_rden),
		.busy_flags(busy_flags), .wbuf_byte(wbuf_byte), .status(status)
	);

endmodule

/* src/status_reg.sv */
// status register, collects flash and bridge state into one 32-bit word
module status_reg (
	input  logic                                  clock_rd2,
	input  logic                                  rst_n,
	cmd_level_if.stat                             lv,
	input  logic                                  busy_q,
	input  logic                                  flash_data_valid,
	input  logic                                  flash_illegal_write,
	input  logic                                  flash_illegal_erase,
	input  logic                                  flash_rden,
	input  logic [flash_buf_pkg::BUSY_EDGES-1:0]  busy_flags,
	input  logic [flash_buf_pkg::BYTE_W-1:0]      wbuf_byte,
	output logic [31:0]                           status
);
	import flash_buf_pkg::*;

	always_ff @(posedge clock_rd2 or negedge rst_n) begin
		if (!rst_n) begin
			status <= '0;
		end else begin
			status                          <= '0;	// 23:8 unused
			status[ST_BUSY]                 <= busy_q;
			status[ST_VALID]                <= flash_data_valid;
			status[ST_ILL_WR]               <= flash_illegal_write;
			status[ST_ILL_ER]               <= flash_illegal_erase;
			// flags read as clear from the cycle the clear is issued
			status[ST_BUSY_RISE]            <= busy_flags[0] && !lv.busy_clear;
			status[ST_BUSY_FALL]            <= busy_flags[1] && !lv.busy_clear;
			status[ST_READ_EN]              <= flash_rden;
			status[ST_BUF_WR]               <= lv.buf_wr;
			status[ST_WBYTE_LSB +: BYTE_W]  <= wbuf_byte;
		end
	end

endmodule

/* src/write_sequencer.sv */
// write sequencer, host write buffer plus page program FSM shifting bytes out
module write_sequencer (
	input  logic                              clock_rd2,
	input  logic                              rst_n,
	cmd_level_if.writer                       lv,
	input  logic                              host_wr_strobe,
	input  logic [flash_buf_pkg::BUF_AW-1:0]  host_wr_addr,
	input  logic [flash_buf_pkg::BYTE_W-1:0]  host_wr_byte,
	output logic [flash_buf_pkg::BYTE_W-1:0]  wbuf_byte,
	output logic [flash_buf_pkg::BYTE_W-1:0]  flash_din,
	output logic                              shift_bytes,
	output logic                              write_done
);
	import flash_buf_pkg::*;

	write_state_e      state;
	logic [BUF_AW-1:0] byte_cnt;	// byte being shifted
	logic              strb_q;	// host strobe one cycle back
	logic              rise_q;	// registered strobe edge
	logic [BYTE_W-1:0] page_byte;

	// ========================================
	// host side, one write per strobe
	// ========================================
	always_ff @(posedge clock_rd2 or negedge rst_n) begin
		if (!rst_n) begin
			strb_q <= 1'b0;
			rise_q <= 1'b0;
		end else begin
			strb_q <= host_wr_strobe;
			rise_q <= host_wr_strobe && !strb_q;
		end
	end

	// ========================================
	// page program FSM
	// ========================================
	always_ff @(posedge clock_rd2 or negedge rst_n) begin
		if (!rst_n) begin
			state    <= WS_LOAD;
			byte_cnt <= '0;
		end else if (!lv.wr) begin
			state    <= WS_LOAD;	// abort or idle, start over at byte 0
			byte_cnt <= '0;
		end else begin
			case (state)
				WS_LOAD:  state <= WS_SHIFT;
				WS_SHIFT: state <= WS_NEXT;
				WS_NEXT: begin
					if (byte_cnt < BUF_AW'(PAGE_BYTES - 1)) begin
						byte_cnt <= byte_cnt + 1'b1;
						state    <= WS_LOAD;
					end else begin
						state <= WS_DONE;
					end
				end
				default:  state <= WS_DONE;	// hold until wr drops
			endcase
		end
	end

	assign shift_bytes = (state == WS_SHIFT);
	assign write_done  = (state == WS_DONE);
	assign flash_din   = {<<{page_byte}};	// flash takes bytes lsb first

	byte_ram u_wbuf (
		.clock_rd2 (clock_rd2),
		.addr_a    (host_wr_addr),
		.din_a     (host_wr_byte),
		.we_a      (lv.buf_wr && rise_q),
		.dout_a    (wbuf_byte),	// readback for the status word
		.addr_b    (byte_cnt),
		.dout_b    (page_byte)
	);

	a_cnt_in_page : assert property (@(posedge clock_rd2) disable iff (!rst_n)
		byte_cnt <= BUF_AW'(PAGE_BYTES - 1))
		else $error("write_sequencer: byte counter past the page");

endmodule

/* src/read_capture.sv */
// read capture, counts flash bytes of a read and stores them bit-reversed
module read_capture (
	input  logic                              clock_rd2,
	input  logic                              rst_n,
	cmd_level_if.reader                       lv,
	input  logic [flash_buf_pkg::BUF_AW-1:0]  read_len,
	input  logic                              flash_data_valid,
	input  logic [flash_buf_pkg::BYTE_W-1:0]  flash_dout,
	input  logic [flash_buf_pkg::BUF_AW-1:0]  host_rd_addr,
	output logic                              flash_rden,
	output logic [flash_buf_pkg::BYTE_W-1:0]  rd_data
);
	import flash_buf_pkg::*;

	logic [BUF_AW-1:0] byte_cnt;	// buffer slot of the current byte
	logic              dv_q;	// data_valid one cycle back
	logic [BYTE_W-1:0] dout_rev;
	logic              cap_we;

	// ========================================
	// byte counter
	// ========================================
	always_ff @(posedge clock_rd2 or negedge rst_n) begin
		if (!rst_n) begin
			byte_cnt <= '0;
			dv_q     <= 1'b0;
		end else if (lv.rd) begin
			dv_q <= flash_data_valid;
			if (dv_q && !flash_data_valid && byte_cnt <= read_len)
				byte_cnt <= byte_cnt + 1'b1;	// step on the falling edge of data_valid
		end else begin
			byte_cnt <= '0;	// idle between reads
			dv_q     <= 1'b0;
		end
	end

	// read stays enabled for read_len+1 bytes
	assign flash_rden = lv.rd && (byte_cnt <= read_len);
	assign cap_we     = flash_rden && flash_data_valid;
	assign dout_rev   = {<<{flash_dout}};	// flash returns bytes lsb first

	byte_ram u_rbuf (
		.clock_rd2 (clock_rd2),
		.addr_a    (byte_cnt),
		.din_a     (dout_rev),
		.we_a      (cap_we),
		.dout_a    (),	// capture side only writes
		.addr_b    (host_rd_addr),
		.dout_b    (rd_data)
	);

endmodule

/* src/flash_strobe.sv */
// flash strobe generator, one-cycle pulses from command levels plus busy and address regs
module flash_strobe (
	input  logic                                clock_rd2,
	input  logic                                rst_n,
	cmd_level_if.strobe                         lv,
	input  logic                                write_done,
	input  logic                                shift_bytes,
	input  logic                                flash_busy,
	input  logic [flash_buf_pkg::FLASH_AW-1:0]  flash_addr_in,
	output logic                                flash_read,
	output logic                                flash_sector_erase,
	output logic                                flash_en4b,
	output logic                                flash_write,
	output logic                                flash_wren,
	output logic [flash_buf_pkg::FLASH_AW-1:0]  flash_addr,
	output logic                                busy_q
);
	import flash_buf_pkg::*;

	// source order: 0 read, 1 erase, 2 en4b, 3 write
	logic [3:0]      src;
	logic [3:0][1:0] hist;	// {older, newer} sample per source
	logic [3:0]      pulse;

	assign src = {write_done, lv.ext_addr, lv.erase, lv.rd};

	always_ff @(posedge clock_rd2 or negedge rst_n) begin
		if (!rst_n) begin
			hist   <= '0;
			busy_q <= 1'b0;
		end else begin
			for (int i = 0; i < 4; i++)
				hist[i] <= {hist[i][0], src[i]};
			busy_q <= flash_busy;	// reported only, never waited on
		end
	end

	// address is payload, follows the host one edge late
	always_ff @(posedge clock_rd2) begin
		flash_addr <= flash_addr_in;
	end

	always_comb begin
		for (int i = 0; i < 4; i++)
			pulse[i] = (hist[i] == 2'b01);	// rising edge, one cycle only
	end

	assign flash_read         = pulse[0];
	assign flash_sector_erase = pulse[1];
	assign flash_en4b         = pulse[2];
	assign flash_write        = pulse[3];
	assign flash_wren         = pulse[1] | pulse[2] | pulse[3] | shift_bytes;	// shared write enable

	// write_done comes from the sequencer, the rest from the decoder
	a_one_strobe : assert property (@(posedge clock_rd2) disable iff (!rst_n) $onehot0(pulse))
		else $error("flash_strobe: two flash strobes in one cycle");

endmodule

/* src/cmd_decode.sv */
// command decoder, registers the host opcode and drives one-hot command levels
module cmd_decode (
	input  logic                           clock_rd2,
	input  logic                           rst_n,
	input  logic [flash_cmd_pkg::CMD_W-1:0] cmd,
	cmd_level_if.src                       lv
);
	import flash_cmd_pkg::*;

	logic [CMD_W-1:0] op_q;	// opcode one edge after the host

	// two stages: opcode first, then the levels decoded from it
	always_ff @(posedge clock_rd2 or negedge rst_n) begin
		if (!rst_n) begin
			op_q          <= OP_IDLE;
			lv.rd         <= 1'b0;
			lv.wr         <= 1'b0;
			lv.erase      <= 1'b0;
			lv.ext_addr   <= 1'b0;
			lv.buf_wr     <= 1'b0;
			lv.busy_clear <= 1'b0;
		end else begin
			op_q          <= cmd;
			lv.rd         <= (op_q == OP_READ);
			lv.wr         <= (op_q == OP_WRITE);
			lv.erase      <= (op_q == OP_ERASE);
			lv.ext_addr   <= (op_q == OP_EXT_ADDR);
			lv.buf_wr     <= (op_q == OP_BUF_WRITE);
			lv.busy_clear <= (op_q == OP_BUSY_CLEAR);	// unknown codes leave all low
		end
	end

	// every consumer relies on a single active command at a time
	a_levels_onehot : assert property (@(posedge clock_rd2) disable iff (!rst_n)
		$onehot0({lv.rd, lv.wr, lv.erase, lv.ext_addr, lv.buf_wr, lv.busy_clear}))
		else $error("cmd_decode: more than one command level high");

endmodule

/* src/edge_latch.sv */
// sticky edge flag, sets on a rising level and holds until cleared
module edge_latch #(
	parameter logic PREV_INIT = 1'b0	// held level out of reset, matches the source
) (
	input  logic clock_rd2,
	input  logic rst_n,
	input  logic level,
	input  logic clear,
	output logic flag
);
	logic level_q;	// level one cycle back

	always_ff @(posedge clock_rd2 or negedge rst_n) begin
		if (!rst_n) begin
			level_q <= PREV_INIT;
			flag    <= 1'b0;
		end else begin
			level_q <= level;
			if (clear)
				flag <= 1'b0;	// clear beats a new edge
			else if (level && !level_q)
				flag <= 1'b1;
		end
	end

endmodule

/* src/byte_ram.sv */
// byte buffer, 256x8 with read/write port a and read-only port b
module byte_ram (
	input  logic                              clock_rd2,
	input  logic [flash_buf_pkg::BUF_AW-1:0]  addr_a,
	input  logic [flash_buf_pkg::BYTE_W-1:0]  din_a,
	input  logic                              we_a,
	output logic [flash_buf_pkg::BYTE_W-1:0]  dout_a,
	input  logic [flash_buf_pkg::BUF_AW-1:0]  addr_b,
	output logic [flash_buf_pkg::BYTE_W-1:0]  dout_b
);
	import flash_buf_pkg::*;

	logic [BYTE_W-1:0] mem [2**BUF_AW];

	// port a, old data on a same-address write
	always_ff @(posedge clock_rd2) begin
		if (we_a)
			mem[addr_a] <= din_a;
		dout_a <= mem[addr_a];
	end

	// port b, one cycle read latency
	always_ff @(posedge clock_rd2) begin
		dout_b <= mem[addr_b];
	end

endmodule

/* src/cmd_level_if.sv */
// decoded command levels, one driver and one view per consumer
interface cmd_level_if;
	logic rd;	// read in progress
	logic wr;	// page program in progress
	logic erase;	// sector erase requested
	logic ext_addr;	// four byte address enable requested
	logic buf_wr;	// host may fill the write buffer
	logic busy_clear;	// drop the sticky busy flags

	// decoder owns every level
	modport src (output rd, wr, erase, ext_addr, buf_wr, busy_clear);

	modport reader (input rd);
	modport writer (input wr, buf_wr);
	modport strobe (input rd, erase, ext_addr);
	modport stat (input buf_wr, busy_clear);	// status word and flag masking

endinterface

/* src/flash_buf_pkg.sv */
// flash buffer package, buffer geometry, write FSM states and status layout
package flash_buf_pkg;

	// ========================================
	// buffer geometry
	// ========================================
	localparam int BYTE_W     = 8;	// one flash byte
	localparam int BUF_AW     = 8;	// 256 entry buffers
	localparam int PAGE_BYTES = 128;	// bytes shifted per page program
	localparam int FLASH_AW   = 32;	// flash byte address
	localparam int BUSY_EDGES = 2;	// rise and fall latches

	// page program sequencer, three cycles per byte
	typedef enum logic [1:0] {
		WS_LOAD  = 2'd0,	// buffer output settles
		WS_SHIFT = 2'd1,	// byte goes out
		WS_NEXT  = 2'd2,	// step counter or finish
		WS_DONE  = 2'd3	// hold write request
	} write_state_e;

	// ========================================
	// status word bit positions
	// ========================================
	localparam int ST_BUSY      = 0;
	localparam int ST_VALID     = 1;
	localparam int ST_ILL_WR    = 2;
	localparam int ST_ILL_ER    = 3;
	localparam int ST_BUSY_RISE = 4;
	localparam int ST_BUSY_FALL = 5;
	localparam int ST_READ_EN   = 6;
	localparam int ST_BUF_WR    = 7;
	localparam int ST_WBYTE_LSB = 24;	// write buffer byte in 31:24

endpackage

/* src/flash_cmd_pkg.sv */
// flash command package, host opcode encoding and command width
package flash_cmd_pkg;

	// ========================================
	// widths
	// ========================================
	localparam int CMD_W = 8;	// host opcode byte

	// ========================================
	// host opcodes
	// ========================================
	// only the low byte of the host control word carries the opcode
	typedef enum logic [CMD_W-1:0] {
		OP_IDLE       = 8'h00,	// nothing selected, all levels low
		OP_READ       = 8'h09,	// read into the read buffer
		OP_WRITE      = 8'h0A,	// page program from the write buffer
		OP_EXT_ADDR   = 8'h0B,	// enable four byte addressing
		OP_ERASE      = 8'h0C,	// sector erase
		OP_BUF_WRITE  = 8'h0D,	// host fills the write buffer
		OP_BUSY_CLEAR = 8'h0E	// clear sticky busy edge flags
	} flash_op_e;

endpackage
